// ==== Bender.yml ====
package:
  name: cmddec

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/cmddec_pkg.sv
      - logic/cs_field_if.sv
      - logic/regfile_strobe_decode.sv
      - logic/comm_decode.sv
      - logic/cache_level_decode.sv
      - logic/cmddec.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/cmddec_chk.sv
      - tests/tb_cmddec.sv

// ==== logic/cache_level_decode.sv ====
// Cache and level zero decode
`timescale 1ns/1ps

module cache_level_decode import cmddec_pkg::*; (
   input  logic clk,
   input  logic rst_n,
   input  pil_t pil,    // Current interrupt level
   input  logic mreq_n, // Memory request, active low
   input  logic wca_n,  // Write cache, active low
   output logic cup,    // Cache update on read
   output logic cwr,    // Cache write, active high despite the sheet name
   output logic lev0    // Running at level zero
);

   logic mreq;    // Request active
   logic wca;     // Write access
   logic cup_d;
   logic cwr_d;
   logic lev0_d;

   assign mreq = ~mreq_n;
   assign wca  = ~wca_n;

   // Write hits the cache directly
   assign cwr_d = mreq & wca;

   // Read request refreshes the cache line
   assign cup_d = mreq & ~wca;

   // Level decode
   assign lev0_d = (pil == pil_t'(0));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cup  <= 1'b0;
         cwr  <= 1'b0;
         lev0 <= 1'b0;
      end else begin
         cup  <= cup_d;
         cwr  <= cwr_d;
         lev0 <= lev0_d; // One cycle behind pil
      end
   end

endmodule

// ==== logic/cmddec.sv ====
// Command and IDB decode
`timescale 1ns/1ps

module cmddec import cmddec_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  comm_t cs_comm,  // Microinstruction command
   input  idbs_t cs_idbs,  // IDB source select
   input  mis_t  cs_mis,   // Misc field
   input  logic  idb2,
   input  logic  lcs_n,    // Control-store cycle, active low
   input  logic  wrtrf,
   input  pil_t  pil,
   input  logic  mreq_n,
   input  logic  wca_n,
   input  logic  cgabrk_n,
   output logic  rrf_n,
   output logic  erf_n,
   output logic  opclcs,
   output logic  rwcs_n,
   output logic  vex,
   output logic  brk_n,
   output logic  cup,
   output logic  cwr,
   output logic  lev0
);

   // Field bundle for the two microinstruction decoders
   cs_field_if fields ();

   // Source side of the bundle
   assign fields.cs_comm = cs_comm;
   assign fields.cs_idbs = cs_idbs;
   assign fields.cs_mis  = cs_mis;
   assign fields.idb2    = idb2;
   assign fields.lcs_n   = lcs_n;
   assign fields.wrtrf   = wrtrf;

   // Register file strobes
   regfile_strobe_decode u_rf (
      .clk    (clk),
      .rst_n  (rst_n),
      .fields (fields.dec),
      .rrf_n  (rrf_n),
      .erf_n  (erf_n)
   );

   // Control store and vector exception
   comm_decode u_comm (
      .clk      (clk),
      .rst_n    (rst_n),
      .fields   (fields.dec),
      .cgabrk_n (cgabrk_n),
      .opclcs   (opclcs),
      .rwcs_n   (rwcs_n),
      .vex      (vex),
      .brk_n    (brk_n)
   );

   // Cache and level, plain ports
   cache_level_decode u_cache (
      .clk    (clk),
      .rst_n  (rst_n),
      .pil    (pil),
      .mreq_n (mreq_n),
      .wca_n  (wca_n),
      .cup    (cup),
      .cwr    (cwr),
      .lev0   (lev0)
   );

endmodule

// ==== logic/cmddec_macros.svh ====
// Command decode field codes
`ifndef CMDDEC_MACROS_SVH
`define CMDDEC_MACROS_SVH

// Field widths of the microinstruction
`define CMDDEC_COMM_W 5 // Command field
`define CMDDEC_IDBS_W 5 // IDB source select
`define CMDDEC_MIS_W  2 // Misc field
`define CMDDEC_PIL_W  4 // Priority interrupt level

// IDB source code that puts the register file on the bus
`define CMDDEC_IDBS_RF 5'h1e

// Command codes, all distinct
`define CMDDEC_COMM_OPCLCS 5'h0d // Operate on control store
`define CMDDEC_COMM_RWCS   5'h0e // Read or write control store
`define CMDDEC_COMM_VEX    5'h17 // Raise vector exception
`define CMDDEC_COMM_CLRVEX 5'h16 // Clear vector exception

// Misc qualifier for the raise command
`define CMDDEC_MIS_VEX 2'b10

`endif

// ==== logic/cmddec_pkg.sv ====
// Command decode field types
`include "cmddec_macros.svh"

package cmddec_pkg;

   // Microinstruction command field
   typedef logic [`CMDDEC_COMM_W-1:0] comm_t;

   // Source select for the internal data bus
   typedef logic [`CMDDEC_IDBS_W-1:0] idbs_t;

   // Misc field, qualifies some commands
   typedef logic [`CMDDEC_MIS_W-1:0] mis_t;

   // Current priority interrupt level
   typedef logic [`CMDDEC_PIL_W-1:0] pil_t;

endpackage

// ==== logic/comm_decode.sv ====
// Command field decode
`timescale 1ns/1ps
`include "cmddec_macros.svh"

module comm_decode (
   input  logic    clk,
   input  logic    rst_n,
   cs_field_if.dec fields,
   input  logic    cgabrk_n, // Break request from the gate array
   output logic    opclcs,   // Operate on control store
   output logic    rwcs_n,   // Control-store read/write, active low
   output logic    vex,      // Sticky vector exception
   output logic    brk_n     // Break line
);

   logic is_opclcs; // Command hits
   logic is_rwcs;
   logic is_vex;
   logic is_clrvex;
   logic vex_set;   // Qualified raise
   logic vex_d;

   // Plain compares on the command field
   assign is_opclcs = (fields.cs_comm == `CMDDEC_COMM_OPCLCS);
   assign is_rwcs   = (fields.cs_comm == `CMDDEC_COMM_RWCS);
   assign is_vex    = (fields.cs_comm == `CMDDEC_COMM_VEX);
   assign is_clrvex = (fields.cs_comm == `CMDDEC_COMM_CLRVEX);

   // Raise needs the misc code and IDB2 as well
   assign vex_set = is_vex & (fields.cs_mis == `CMDDEC_MIS_VEX) & fields.idb2;

   // Set, clear or hold
   always_comb begin
      if (vex_set) begin
         vex_d = 1'b1;
      end else if (is_clrvex) begin
         vex_d = 1'b0;
      end else begin
         vex_d = vex; // Hold
      end
   end

   // Outputs one cycle after the fields
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         opclcs <= 1'b0;
         rwcs_n <= 1'b1;
         vex    <= 1'b0; // No exception pending
      end else begin
         opclcs <= is_opclcs & ~fields.lcs_n; // Only in a CS cycle
         rwcs_n <= ~is_rwcs;
         vex    <= vex_d;
      end
   end

   // NAND of the inverted inputs, high if either source is high
   assign brk_n = ~(~cgabrk_n & ~vex);

endmodule

// ==== logic/cs_field_if.sv ====
// Microinstruction field bundle
`timescale 1ns/1ps

interface cs_field_if import cmddec_pkg::*; ();

   comm_t cs_comm; // Command field
   idbs_t cs_idbs; // IDB source select
   mis_t  cs_mis;  // Misc field
   logic  idb2;    // IDB bit 2, qualifies VEX
   logic  lcs_n;   // Low during a control-store cycle
   logic  wrtrf;   // Write register file

   // Driving side, fed from the top-level ports
   modport src (
      output cs_comm,
      output cs_idbs,
      output cs_mis,
      output idb2,
      output lcs_n,
      output wrtrf
   );

   // Decoder side
   modport dec (
      input cs_comm,
      input cs_idbs,
      input cs_mis,
      input idb2,
      input lcs_n,
      input wrtrf
   );

endinterface

// ==== logic/regfile_strobe_decode.sv ====
// Register file strobe decode
`timescale 1ns/1ps
`include "cmddec_macros.svh"

module regfile_strobe_decode (
   input  logic           clk,
   input  logic           rst_n,
   cs_field_if.dec        fields,
   output logic           rrf_n, // Read register file, active low
   output logic           erf_n  // Enable register file write, active low
);

   logic rf_sel;   // Register file selected as IDB source
   logic cs_cycle; // Control-store cycle in progress
   logic rrf_d;
   logic erf_d;

   // Source decode
   assign rf_sel   = (fields.cs_idbs == `CMDDEC_IDBS_RF);
   assign cs_cycle = ~fields.lcs_n;

   // Both strobes blocked during control-store access
   assign rrf_d = rf_sel & ~cs_cycle;
   assign erf_d = fields.wrtrf & ~cs_cycle;

   // Registered strobes, one cycle behind the fields
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rrf_n <= 1'b1; // Idle high
         erf_n <= 1'b1;
      end else begin
         rrf_n <= ~rrf_d;
         erf_n <= ~erf_d;
      end
   end

endmodule

// ==== project.f ====
+incdir+logic
logic/cmddec_pkg.sv
logic/cs_field_if.sv
logic/regfile_strobe_decode.sv
logic/comm_decode.sv
logic/cache_level_decode.sv
logic/cmddec.sv
tests/cmddec_chk.sv
tests/tb_cmddec.sv

// ==== tests/cmddec_chk.sv ====
// Decode rule assertions
`timescale 1ns/1ps
`include "cmddec_macros.svh"

module cmddec_chk import cmddec_pkg::*; (
   input logic  clk,
   input logic  rst_n,
   input comm_t cs_comm,
   input idbs_t cs_idbs,
   input mis_t  cs_mis,
   input logic  idb2,
   input logic  lcs_n,
   input logic  wrtrf,
   input pil_t  pil,
   input logic  mreq_n,
   input logic  wca_n,
   input logic  cgabrk_n,
   input logic  rrf_n,
   input logic  erf_n,
   input logic  opclcs,
   input logic  rwcs_n,
   input logic  vex,
   input logic  brk_n,
   input logic  cup,
   input logic  cwr,
   input logic  lev0
);

   logic err = 1'b0; // Sticky, watched by the testbench
   logic vex_raise;  // Qualified raise in the current fields
   logic vex_clear;

   assign vex_raise = (cs_comm == `CMDDEC_COMM_VEX) && (cs_mis == `CMDDEC_MIS_VEX) && idb2;
   assign vex_clear = (cs_comm == `CMDDEC_COMM_CLRVEX);

   // First edge out of reset sees the reset values
   a_reset: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(rst_n) |-> rrf_n && erf_n && rwcs_n && !opclcs && !vex
                       && !cup && !cwr && !lev0 && (brk_n == cgabrk_n))
   else begin
      $error("FAIL %0t: outputs not at reset values after reset", $time);
      err = 1'b1;
   end

   // Register file strobes, blocked in a CS cycle
   a_rf: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) |->
         (rrf_n == !(($past(cs_idbs) == `CMDDEC_IDBS_RF) && $past(lcs_n)))
         && (erf_n == !($past(wrtrf) && $past(lcs_n))))
   else begin
      $error("FAIL %0t: register file strobe rule", $time);
      err = 1'b1;
   end

   // Control store commands
   a_cs: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) |->
         (opclcs == (($past(cs_comm) == `CMDDEC_COMM_OPCLCS) && !$past(lcs_n)))
         && (rwcs_n == ($past(cs_comm) != `CMDDEC_COMM_RWCS)))
   else begin
      $error("FAIL %0t: control store command rule", $time);
      err = 1'b1;
   end

   // Sticky exception, set wins over hold
   a_vex: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) |->
         vex == ($past(vex_raise) ? 1'b1 : ($past(vex_clear) ? 1'b0 : $past(vex))))
   else begin
      $error("FAIL %0t: vector exception set, clear or hold rule", $time);
      err = 1'b1;
   end

   a_brk: assert property (@(posedge clk) disable iff (!rst_n)
      brk_n == (cgabrk_n || vex)) // Combinational
   else begin
      $error("FAIL %0t: break line rule", $time);
      err = 1'b1;
   end

   // Cache and level
   a_cache: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) |->
         (lev0 == ($past(pil) == '0))
         && (cwr == (!$past(mreq_n) && !$past(wca_n)))
         && (cup == (!$past(mreq_n) && $past(wca_n))))
   else begin
      $error("FAIL %0t: cache or level zero rule", $time);
      err = 1'b1;
   end

endmodule

// ==== tests/tb_cmddec.sv ====
// Command decode testbench
`timescale 1ns/1ps
`include "cmddec_macros.svh"

module tb_cmddec import cmddec_pkg::*; ();

   localparam int N_CYCLES   = 2000; // Stimulus cycles
   localparam int MAX_CYCLES = 2100; // Reset, stimulus, margin

   logic        clk = 1'b0;
   logic        rst_n;
   comm_t       cs_comm;
   idbs_t       cs_idbs;
   mis_t        cs_mis;
   logic        idb2;
   logic        lcs_n;
   logic        wrtrf;
   pil_t        pil;
   logic        mreq_n;
   logic        wca_n;
   logic        cgabrk_n;
   logic        rrf_n;
   logic        erf_n;
   logic        opclcs;
   logic        rwcs_n;
   logic        vex;
   logic        brk_n;
   logic        cup;
   logic        cwr;
   logic        lev0;
   logic [31:0] lfsr = 32'h7e0094d8;
   int          cycle_cnt = 0;

   always #2 clk = ~clk; // 4 ns period

   cmddec UUT (
      .clk(clk), .rst_n(rst_n), .cs_comm(cs_comm), .cs_idbs(cs_idbs), .cs_mis(cs_mis),
      .idb2(idb2), .lcs_n(lcs_n), .wrtrf(wrtrf), .pil(pil), .mreq_n(mreq_n),
      .wca_n(wca_n), .cgabrk_n(cgabrk_n), .rrf_n(rrf_n), .erf_n(erf_n),
      .opclcs(opclcs), .rwcs_n(rwcs_n), .vex(vex), .brk_n(brk_n), .cup(cup),
      .cwr(cwr), .lev0(lev0)
   );

   // Checker sees every port of the decode top
   bind cmddec cmddec_chk u_chk (
      .clk(clk), .rst_n(rst_n), .cs_comm(cs_comm), .cs_idbs(cs_idbs), .cs_mis(cs_mis),
      .idb2(idb2), .lcs_n(lcs_n), .wrtrf(wrtrf), .pil(pil), .mreq_n(mreq_n),
      .wca_n(wca_n), .cgabrk_n(cgabrk_n), .rrf_n(rrf_n), .erf_n(erf_n),
      .opclcs(opclcs), .rwcs_n(rwcs_n), .vex(vex), .brk_n(brk_n), .cup(cup),
      .cwr(cwr), .lev0(lev0)
   );

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr); // One step per bit
         val  = {val[30:0], lfsr[0]};
      end
   endtask

   // Decoded code one time in four or a random value
   task automatic field_value(input int width, input logic [31:0] code,
                              output logic [31:0] val);
      logic [31:0] pick;
      draw_bits(2, pick);
      if (pick[1:0] == 2'd0) begin
         val = code;
      end else begin
         draw_bits(width, val);
      end
   endtask

   task automatic drive_random();
      logic [31:0] sel;
      logic [31:0] code;
      logic [31:0] val;
      draw_bits(2, sel); // Which command code to aim at
      case (sel[1:0])
         2'd0:    code = `CMDDEC_COMM_OPCLCS;
         2'd1:    code = `CMDDEC_COMM_RWCS;
         2'd2:    code = `CMDDEC_COMM_VEX;
         default: code = `CMDDEC_COMM_CLRVEX;
      endcase
      field_value(`CMDDEC_COMM_W, code, val);
      cs_comm = comm_t'(val);
      field_value(`CMDDEC_IDBS_W, `CMDDEC_IDBS_RF, val);
      cs_idbs = idbs_t'(val);
      field_value(`CMDDEC_MIS_W, `CMDDEC_MIS_VEX, val);
      cs_mis = mis_t'(val);
      field_value(`CMDDEC_PIL_W, 0, val);
      pil = pil_t'(val);
      draw_bits(6, val); // Single-bit controls
      {idb2, lcs_n, wrtrf, mreq_n, wca_n, cgabrk_n} = val[5:0];
   endtask

   task automatic stop_with_failure(input string why);
      $display("TEST FAILED");
      $fatal(1, "%s", why);
   endtask

   // Assertion failures land here
   always @(UUT.u_chk.err) begin
      if (UUT.u_chk.err === 1'b1) begin
         stop_with_failure("a decode assertion failed");
      end
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         stop_with_failure("timeout, stimulus did not finish within the cycle limit");
      end
   end

   initial begin
      rst_n    = 1'b0;
      cs_comm  = '0;
      cs_idbs  = '0;
      cs_mis   = '0;
      idb2     = 1'b0;
      lcs_n    = 1'b1;
      wrtrf    = 1'b0;
      pil      = '0;
      mreq_n   = 1'b1;
      wca_n    = 1'b1;
      cgabrk_n = 1'b0; // Break line follows vex only
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int c = 0; c < N_CYCLES; c++) begin
         @(posedge clk);
         #1;
         drive_random();
      end
      repeat (3) @(posedge clk); // Let the last checks fire
      #1;
      if (UUT.u_chk.err) begin
         stop_with_failure("a decode assertion failed");
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule
